//--- source/kbd_pkg.sv
`default_nettype none

package kbd_pkg;

	typedef logic [7:0] code_t;

	typedef logic [7:0] count_t;

	localparam code_t BREAK_CODE = 8'hf0; // release prefix.

	typedef enum logic {
		wait_code,
		wait_release // next code is the released key.
	} tracker_state_t;

	typedef enum logic {
		count_hex,
		count_dec
	} count_mode_t;

endpackage

`default_nettype wire

//--- source/ps2_receiver.sv
`default_nettype none
`timescale 1ns/10ps

module ps2_receiver #(
	parameter int QUEUE_DEPTH = 4
) (
	input wire clk,
	input wire reset,
	input wire ps2_clk,
	input wire ps2_data,
	input wire credit_return,
	output kbd_pkg::code_t code,
	output logic code_valid,
	output logic [7:0] frame_errors,
	output logic [7:0] drop_count
);

	localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);

	logic [2:0] clk_sync; // two sync flops plus last sample.
	logic [1:0] data_sync;
	logic [10:0] shift;
	logic [3:0] bit_cnt;
	logic frame_done;
	logic frame_good;
	logic frame_bad;
	kbd_pkg::code_t frame_code;
	logic [CREDIT_W-1:0] credits;
	logic clk_fall;
	logic send;

	assign clk_fall = clk_sync[2] & ~clk_sync[1];
	assign send = frame_good && (credits != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			clk_sync <= 3'b111;
			data_sync <= 2'b11;
		end else begin
			clk_sync <= {clk_sync[1:0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (clk_fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt <= '0;
					frame_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	// lsb first, start bit ends up in shift[0].
	always_ff @(posedge clk) begin
		if (clk_fall)
			shift <= {data_sync[1], shift[10:1]};
		if (frame_done)
			frame_code <= shift[8:1];
		if (send)
			code <= frame_code;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			frame_good <= 1'b0;
			frame_bad <= 1'b0;
			code_valid <= 1'b0;
			credits <= CREDIT_W'(QUEUE_DEPTH);
			frame_errors <= '0;
			drop_count <= '0;
		end else begin
			frame_good <= frame_done && !shift[0] && shift[10] && (^shift[9:1]); // odd parity.
			frame_bad <= frame_done && !(!shift[0] && shift[10] && (^shift[9:1]));
			code_valid <= send;
			case ({send, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			if (frame_bad && frame_errors != 8'hff)
				frame_errors <= frame_errors + 8'd1;
			if (frame_good && credits == '0 && drop_count != 8'hff)
				drop_count <= drop_count + 8'd1; // no room downstream.
		end
	end

endmodule

`default_nettype wire

//--- source/scan_queue.sv
`default_nettype none
`timescale 1ns/10ps

module scan_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input wire clk,
	input wire reset,
	input wire kbd_pkg::code_t code,
	input wire code_valid,
	input wire pop,
	output kbd_pkg::code_t head,
	output logic not_empty,
	output logic credit_return
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	kbd_pkg::code_t mem [QUEUE_DEPTH];
	logic [PTR_W:0] wr_ptr; // extra bit tells full from empty.
	logic [PTR_W:0] rd_ptr;

	assign not_empty = (wr_ptr != rd_ptr);
	assign head = mem[rd_ptr[PTR_W-1:0]];

	always_ff @(posedge clk) begin
		if (code_valid)
			mem[wr_ptr[PTR_W-1:0]] <= code;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			credit_return <= 1'b0;
		end else begin
			if (code_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			credit_return <= pop; // one credit per entry freed.
		end
	end

endmodule

`default_nettype wire

//--- source/key_tracker.sv
`default_nettype none
`timescale 1ns/10ps

module key_tracker (
	input wire clk,
	input wire reset,
	input wire kbd_pkg::code_t head,
	input wire not_empty,
	input wire freeze,
	output logic pop,
	output kbd_pkg::code_t key_code,
	output logic key_held,
	output kbd_pkg::count_t press_count
);

	kbd_pkg::tracker_state_t state;

	assign pop = not_empty & ~freeze;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= kbd_pkg::wait_code;
			key_code <= '0;
			key_held <= 1'b0;
			press_count <= '0;
		end else if (pop) begin
			case (state)
				kbd_pkg::wait_code: begin
					if (head == kbd_pkg::BREAK_CODE) begin
						state <= kbd_pkg::wait_release;
					end else begin
						if (!(key_held && key_code == head))
							press_count <= press_count + 8'd1; // typematic repeat skipped.
						key_code <= head;
						key_held <= 1'b1;
					end
				end
				kbd_pkg::wait_release: begin
					if (head == key_code)
						key_held <= 1'b0;
					state <= kbd_pkg::wait_code;
				end
				default: state <= kbd_pkg::wait_code;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/display_config.sv
`default_nettype none
`timescale 1ns/10ps

module display_config (
	input wire clk,
	input wire reset,
	input wire cfg_write,
	input wire [9:0] cfg_data,
	output logic freeze,
	output kbd_pkg::count_mode_t count_mode,
	output logic [7:0] blank_mask
);

	always_ff @(posedge clk) begin
		if (reset) begin
			freeze <= 1'b0;
			count_mode <= kbd_pkg::count_hex;
			blank_mask <= '0;
		end else if (cfg_write) begin
			freeze <= cfg_data[0];
			count_mode <= kbd_pkg::count_mode_t'(cfg_data[1]);
			blank_mask <= cfg_data[9:2]; // one bit per digit.
		end
	end

endmodule

`default_nettype wire

//--- source/seg_display.sv
`default_nettype none
`timescale 1ns/10ps

module seg_display (
	input wire clk,
	input wire reset,
	input wire kbd_pkg::code_t key_code,
	input wire key_held,
	input wire kbd_pkg::count_t press_count,
	input wire kbd_pkg::count_mode_t count_mode,
	input wire [7:0] blank_mask,
	output logic [7:0] seg0,
	output logic [7:0] seg1,
	output logic [7:0] seg2,
	output logic [7:0] seg3,
	output logic [7:0] seg4,
	output logic [7:0] seg5,
	output logic [7:0] seg6,
	output logic [7:0] seg7
);

	localparam logic [7:0] BLANK = 8'hff;
	localparam logic [7:0] ZERO = 8'hc0;

	kbd_pkg::count_t count_mod;
	logic [3:0] count_lo;
	logic [3:0] count_hi;
	logic [7:0] digit [8];

	// active low, gfedcba in bits 6..0, dot off.
	function automatic logic [7:0] hex_to_seg(input logic [3:0] value);
		logic [7:0] pattern;
		case (value)
			4'h0: pattern = 8'hc0;
			4'h1: pattern = 8'hf9;
			4'h2: pattern = 8'ha4;
			4'h3: pattern = 8'hb0;
			4'h4: pattern = 8'h99;
			4'h5: pattern = 8'h92;
			4'h6: pattern = 8'h82;
			4'h7: pattern = 8'hf8;
			4'h8: pattern = 8'h80;
			4'h9: pattern = 8'h90;
			4'ha: pattern = 8'h88;
			4'hb: pattern = 8'h83;
			4'hc: pattern = 8'hc6;
			4'hd: pattern = 8'ha1;
			4'he: pattern = 8'h86;
			default: pattern = 8'h8e;
		endcase
		return pattern;
	endfunction

	always_comb begin
		count_mod = press_count % 8'd100;
		if (count_mode == kbd_pkg::count_dec) begin
			count_lo = 4'(count_mod % 8'd10);
			count_hi = 4'(count_mod / 8'd10);
		end else begin
			count_lo = press_count[3:0];
			count_hi = press_count[7:4];
		end
		digit[0] = hex_to_seg(count_lo);
		digit[1] = hex_to_seg(count_hi);
		digit[2] = BLANK;
		digit[3] = BLANK;
		digit[4] = key_held ? hex_to_seg(key_code[3:0]) : BLANK;
		digit[5] = key_held ? hex_to_seg(key_code[7:4]) : BLANK;
		digit[6] = BLANK;
		digit[7] = BLANK;
		for (int i = 0; i < 8; i++) begin
			if (blank_mask[i])
				digit[i] = BLANK;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			seg0 <= ZERO; // count shows 00.
			seg1 <= ZERO;
			seg2 <= BLANK;
			seg3 <= BLANK;
			seg4 <= BLANK;
			seg5 <= BLANK;
			seg6 <= BLANK;
			seg7 <= BLANK;
		end else begin
			seg0 <= digit[0];
			seg1 <= digit[1];
			seg2 <= digit[2];
			seg3 <= digit[3];
			seg4 <= digit[4];
			seg5 <= digit[5];
			seg6 <= digit[6];
			seg7 <= digit[7];
		end
	end

endmodule

`default_nettype wire

//--- source/kbd_display_top.sv
`default_nettype none
`timescale 1ns/10ps

module kbd_display_top #(
	parameter int QUEUE_DEPTH = 4
) (
	input wire clk,
	input wire reset,
	input wire ps2_clk,
	input wire ps2_data,
	input wire cfg_write,
	input wire [9:0] cfg_data,
	output logic [7:0] seg0,
	output logic [7:0] seg1,
	output logic [7:0] seg2,
	output logic [7:0] seg3,
	output logic [7:0] seg4,
	output logic [7:0] seg5,
	output logic [7:0] seg6,
	output logic [7:0] seg7,
	output kbd_pkg::code_t key_code,
	output logic key_held,
	output kbd_pkg::count_t press_count,
	output logic [7:0] frame_errors,
	output logic [7:0] drop_count
);

	kbd_pkg::code_t code;
	logic code_valid;
	logic credit_return;
	kbd_pkg::code_t head;
	logic not_empty;
	logic pop;
	logic freeze;
	kbd_pkg::count_mode_t count_mode;
	logic [7:0] blank_mask;

	ps2_receiver #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_ps2_receiver (
		.clk(clk),
		.reset(reset),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.credit_return(credit_return),
		.code(code),
		.code_valid(code_valid),
		.frame_errors(frame_errors),
		.drop_count(drop_count)
	);

	scan_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH) // credits start at the same depth.
	) u_scan_queue (
		.clk(clk),
		.reset(reset),
		.code(code),
		.code_valid(code_valid),
		.pop(pop),
		.head(head),
		.not_empty(not_empty),
		.credit_return(credit_return)
	);

	key_tracker u_key_tracker (
		.clk(clk),
		.reset(reset),
		.head(head),
		.not_empty(not_empty),
		.freeze(freeze),
		.pop(pop),
		.key_code(key_code),
		.key_held(key_held),
		.press_count(press_count)
	);

	display_config u_display_config (
		.clk(clk),
		.reset(reset),
		.cfg_write(cfg_write),
		.cfg_data(cfg_data),
		.freeze(freeze),
		.count_mode(count_mode),
		.blank_mask(blank_mask)
	);

	seg_display u_seg_display (
		.clk(clk),
		.reset(reset),
		.key_code(key_code),
		.key_held(key_held),
		.press_count(press_count),
		.count_mode(count_mode),
		.blank_mask(blank_mask),
		.seg0(seg0),
		.seg1(seg1),
		.seg2(seg2),
		.seg3(seg3),
		.seg4(seg4),
		.seg5(seg5),
		.seg6(seg6),
		.seg7(seg7)
	);

endmodule

`default_nettype wire

//--- verification/kbd_display_sva.sv
`default_nettype none
`timescale 1ns/10ps

module kbd_display_sva #(
	parameter int QUEUE_DEPTH = 4
) (
	input wire clk,
	input wire reset,
	input wire code_valid,
	input wire pop,
	input wire credit_return,
	input wire [$clog2(QUEUE_DEPTH):0] wr_ptr,
	input wire [$clog2(QUEUE_DEPTH):0] rd_ptr
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	int failures = 0;
	logic full;

	assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
		&& (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]); // wrapped once, same slot.

	no_push_when_full: assert property (@(posedge clk) disable iff (reset)
		!(code_valid && full))
	else begin
		failures++;
		$error("push into a full scan queue");
	end

	credit_after_pop: assert property (@(posedge clk) disable iff (reset)
		pop |=> credit_return)
	else begin
		failures++;
		$error("pop without a credit return on the next cycle");
	end

	credit_needs_pop: assert property (@(posedge clk) disable iff (reset)
		credit_return |-> $past(pop))
	else begin
		failures++;
		$error("credit returned without a pop");
	end

endmodule

bind scan_queue kbd_display_sva #(
	.QUEUE_DEPTH(QUEUE_DEPTH)
) u_queue_sva (
	.clk(clk),
	.reset(reset),
	.code_valid(code_valid),
	.pop(pop),
	.credit_return(credit_return),
	.wr_ptr(wr_ptr),
	.rd_ptr(rd_ptr)
);

`default_nettype wire

//--- verification/kbd_display_monitor.sv
`default_nettype none
`timescale 1ns/10ps

module kbd_display_monitor #(
	parameter int QUEUE_DEPTH = 4
) (
	input wire clk,
	input wire reset,
	input wire ps2_clk,
	input wire ps2_data,
	input wire cfg_write,
	input wire [9:0] cfg_data,
	input wire check,
	input wire [7:0] seg0,
	input wire [7:0] seg1,
	input wire [7:0] seg2,
	input wire [7:0] seg3,
	input wire [7:0] seg4,
	input wire [7:0] seg5,
	input wire [7:0] seg6,
	input wire [7:0] seg7,
	input wire [7:0] key_code,
	input wire key_held,
	input wire [7:0] press_count,
	input wire [7:0] frame_errors,
	input wire [7:0] drop_count,
	output logic [7:0] exp_key_code,
	output logic exp_key_held,
	output logic [7:0] exp_count,
	output logic [7:0] exp_errors,
	output logic [7:0] exp_drops,
	output int mismatches
);

	// active low, gfedcba, dot off.
	localparam logic [7:0] SEG_TABLE [16] = '{
		8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
		8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e
	};

	logic [7:0] key_m;
	logic held_m;
	logic [7:0] count_m;
	logic release_m;
	logic [7:0] errors_m;
	logic [7:0] drops_m;
	logic freeze_m;
	logic decimal_m;
	logic [7:0] mask_m;
	logic prev_clk;
	int bit_index;
	logic [10:0] frame_bits;
	logic [7:0] pending [$];
	int error_count = 0;

	task apply_code(input logic [7:0] c);
		if (release_m) begin
			if (c == key_m)
				held_m = 1'b0;
			release_m = 1'b0;
		end else if (c == kbd_pkg::BREAK_CODE) begin
			release_m = 1'b1;
		end else begin
			if (!held_m || key_m != c)
				count_m = count_m + 8'd1; // fresh press only.
			key_m = c;
			held_m = 1'b1;
		end
	endtask

	task judge_frame();
		if (frame_bits[0] || !frame_bits[10] || !(^frame_bits[9:1])) begin
			if (errors_m != 8'hff)
				errors_m = errors_m + 8'd1;
		end else if (!freeze_m) begin
			apply_code(frame_bits[8:1]);
		end else if (pending.size() < QUEUE_DEPTH) begin
			pending.push_back(frame_bits[8:1]);
		end else if (drops_m != 8'hff) begin
			drops_m = drops_m + 8'd1;
		end
	endtask

	function automatic logic [7:0] digit_pattern(input int idx);
		logic [7:0] shown;
		logic [7:0] pattern;
		int tens;
		int units;
		tens = (int'(count_m) % 100) / 10;
		units = int'(count_m) % 10;
		shown = decimal_m ? {4'(tens), 4'(units)} : count_m;
		case (idx)
			0: pattern = SEG_TABLE[shown[3:0]];
			1: pattern = SEG_TABLE[shown[7:4]];
			4: pattern = held_m ? SEG_TABLE[key_m[3:0]] : 8'hff;
			5: pattern = held_m ? SEG_TABLE[key_m[7:4]] : 8'hff;
			default: pattern = 8'hff;
		endcase
		if (mask_m[idx])
			pattern = 8'hff;
		return pattern;
	endfunction

	task compare(input string name, input logic [7:0] got, input logic [7:0] want);
		if (got !== want) begin
			$display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, want);
			error_count++;
		end
	endtask

	task compare_all();
		compare("key_code", key_code, key_m);
		compare("key_held", {7'd0, key_held}, {7'd0, held_m});
		compare("press_count", press_count, count_m);
		compare("frame_errors", frame_errors, errors_m);
		compare("drop_count", drop_count, drops_m);
		compare("seg0", seg0, digit_pattern(0));
		compare("seg1", seg1, digit_pattern(1));
		compare("seg2", seg2, digit_pattern(2));
		compare("seg3", seg3, digit_pattern(3));
		compare("seg4", seg4, digit_pattern(4));
		compare("seg5", seg5, digit_pattern(5));
		compare("seg6", seg6, digit_pattern(6));
		compare("seg7", seg7, digit_pattern(7));
	endtask

	always @(posedge clk) begin
		if (reset) begin
			key_m = '0;
			held_m = 1'b0;
			count_m = '0;
			release_m = 1'b0;
			errors_m = '0;
			drops_m = '0;
			freeze_m = 1'b0;
			decimal_m = 1'b0;
			mask_m = '0;
			prev_clk = 1'b1;
			bit_index = 0;
			pending.delete();
		end else begin
			if (cfg_write) begin
				freeze_m = cfg_data[0];
				decimal_m = cfg_data[1];
				mask_m = cfg_data[9:2];
			end
			while (!freeze_m && pending.size() > 0)
				apply_code(pending.pop_front()); // drains in arrival order.
			if (prev_clk && !ps2_clk) begin
				frame_bits[bit_index] = ps2_data;
				if (bit_index == 10) begin
					bit_index = 0;
					judge_frame();
				end else begin
					bit_index++;
				end
			end
			prev_clk = ps2_clk;
			if (check)
				compare_all();
		end
		exp_key_code <= key_m;
		exp_key_held <= held_m;
		exp_count <= count_m;
		exp_errors <= errors_m;
		exp_drops <= drops_m;
		mismatches <= error_count;
	end

endmodule

`default_nettype wire

//--- verification/kbd_display_tb.sv
`default_nettype none
`timescale 1ns/10ps

module kbd_display_tb;

	localparam int QUEUE_DEPTH = 4;
	localparam int SETTLE_LIMIT = 400; // clk cycles.

	logic clk;
	logic reset;
	logic ps2_clk;
	logic ps2_data;
	logic cfg_write;
	logic [9:0] cfg_data;
	logic check;
	logic [7:0] seg0;
	logic [7:0] seg1;
	logic [7:0] seg2;
	logic [7:0] seg3;
	logic [7:0] seg4;
	logic [7:0] seg5;
	logic [7:0] seg6;
	logic [7:0] seg7;
	kbd_pkg::code_t key_code;
	logic key_held;
	kbd_pkg::count_t press_count;
	logic [7:0] frame_errors;
	logic [7:0] drop_count;
	logic [7:0] exp_key_code;
	logic exp_key_held;
	logic [7:0] exp_count;
	logic [7:0] exp_errors;
	logic [7:0] exp_drops;
	int mismatches;
	integer seed = 32'h779a10b0;
	int timeouts = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int error_base = 0;
	kbd_pkg::code_t held_guess = 8'h1c; // last make sent, used for repeats.

	kbd_display_top #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_kbd_display_top (
		.clk(clk),
		.reset(reset),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.cfg_write(cfg_write),
		.cfg_data(cfg_data),
		.seg0(seg0),
		.seg1(seg1),
		.seg2(seg2),
		.seg3(seg3),
		.seg4(seg4),
		.seg5(seg5),
		.seg6(seg6),
		.seg7(seg7),
		.key_code(key_code),
		.key_held(key_held),
		.press_count(press_count),
		.frame_errors(frame_errors),
		.drop_count(drop_count)
	);

	kbd_display_monitor #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_monitor (
		.clk(clk),
		.reset(reset),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.cfg_write(cfg_write),
		.cfg_data(cfg_data),
		.check(check),
		.seg0(seg0),
		.seg1(seg1),
		.seg2(seg2),
		.seg3(seg3),
		.seg4(seg4),
		.seg5(seg5),
		.seg6(seg6),
		.seg7(seg7),
		.key_code(key_code),
		.key_held(key_held),
		.press_count(press_count),
		.frame_errors(frame_errors),
		.drop_count(drop_count),
		.exp_key_code(exp_key_code),
		.exp_key_held(exp_key_held),
		.exp_count(exp_count),
		.exp_errors(exp_errors),
		.exp_drops(exp_drops),
		.mismatches(mismatches)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#5_000_000;
		$display("watchdog expired before the test sequence finished");
		$display("Test failures found");
		$finish;
	end

	function automatic int error_total();
		return mismatches + timeouts + u_kbd_display_top.u_scan_queue.u_queue_sva.failures;
	endfunction

	task pick_code(output kbd_pkg::code_t c);
		int r;
		r = $random(seed);
		while (r[7:0] == kbd_pkg::BREAK_CODE)
			r = $random(seed);
		c = r[7:0];
	endtask

	// flaw 1 flips parity, 2 the start bit, 3 the stop bit.
	task send_frame(input kbd_pkg::code_t c, input int flaw);
		logic [10:0] bits;
		bits = {1'b1, ~^c, c, 1'b0};
		case (flaw)
			1: bits[9] = ~bits[9];
			2: bits[0] = 1'b1;
			3: bits[10] = 1'b0;
			default: bits = bits;
		endcase
		for (int i = 0; i < 11; i++) begin
			ps2_data <= bits[i];
			repeat (2) @(posedge clk);
			ps2_clk <= 1'b0;
			repeat (4) @(posedge clk);
			ps2_clk <= 1'b1;
			repeat (2) @(posedge clk);
		end
		ps2_data <= 1'b1;
		repeat (16) @(posedge clk); // inter-frame idle.
	endtask

	task write_config(input logic [9:0] value);
		cfg_data <= value;
		cfg_write <= 1'b1;
		@(posedge clk);
		cfg_write <= 1'b0;
		@(posedge clk);
	endtask

	task request_compare();
		check <= 1'b1;
		@(posedge clk);
		check <= 1'b0;
		@(posedge clk);
	endtask

	task settle_and_compare();
		int n;
		n = 0;
		while (n < SETTLE_LIMIT && (key_code !== exp_key_code || key_held !== exp_key_held
				|| press_count !== exp_count || frame_errors !== exp_errors
				|| drop_count !== exp_drops)) begin
			@(posedge clk);
			n++;
		end
		if (n >= SETTLE_LIMIT) begin
			$display("timeout at %0t: outputs did not settle within %0d cycles", $time,
				SETTLE_LIMIT);
			timeouts++;
		end
		repeat (2) @(posedge clk); // segment registers follow.
		request_compare();
	endtask

	task close_test(input string name);
		int total;
		total = error_total();
		tests_run++;
		if (total != error_base) begin
			tests_failed++;
			$display("test %-26s FAILED with %0d errors", name, total - error_base);
		end else begin
			$display("test %-26s ok", name);
		end
		error_base = total;
	endtask

	task random_keys(input int count);
		kbd_pkg::code_t c;
		int r;
		for (int i = 0; i < count; i++) begin
			r = $random(seed);
			case (r[1:0])
				2'd0: begin
					pick_code(c);
					held_guess = c;
					send_frame(c, 0);
				end
				2'd1: send_frame(held_guess, 0); // typematic repeat.
				2'd2: begin
					send_frame(kbd_pkg::BREAK_CODE, 0);
					send_frame(held_guess, 0);
				end
				default: begin
					pick_code(c);
					send_frame(kbd_pkg::BREAK_CODE, 0);
					send_frame(c, 0); // release of a key not held.
				end
			endcase
			settle_and_compare();
		end
	endtask

	initial begin
		kbd_pkg::code_t c;
		int r;
		reset = 1'b1;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		cfg_write = 1'b0;
		cfg_data = '0;
		check = 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		settle_and_compare();
		close_test("after reset");

		random_keys(30);
		close_test("random make/break");

		for (int i = 0; i < 9; i++) begin
			pick_code(c);
			send_frame(c, 1 + i % 3);
			settle_and_compare();
		end
		close_test("bad frames");

		write_config(10'b0000000001);
		for (int i = 0; i < 6; i++) begin
			pick_code(c);
			send_frame(c, 0);
		end
		settle_and_compare();
		write_config(10'b0000000000);
		settle_and_compare();
		close_test("freeze and back-pressure");

		write_config(10'b0000000010);
		for (int i = 0; i < 120 && exp_count < 8'd100; i++) begin
			pick_code(c);
			send_frame(c, 0); // fresh presses take the count past 99.
		end
		settle_and_compare();
		for (int i = 0; i < 6; i++) begin
			r = $random(seed);
			write_config({r[7:0], r[8], 1'b0});
			request_compare();
		end
		write_config(10'b0000000000);
		request_compare();
		close_test("display configuration");

		$display("tests run %0d, failed %0d, mismatches %0d, timeouts %0d", tests_run,
			tests_failed, mismatches, timeouts);
		if (tests_failed == 0 && error_total() == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- kbd_display_top.f
source/kbd_pkg.sv
source/ps2_receiver.sv
source/scan_queue.sv
source/key_tracker.sv
source/display_config.sv
source/seg_display.sv
source/kbd_display_top.sv
verification/kbd_display_sva.sv
verification/kbd_display_monitor.sv
verification/kbd_display_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= kbd_display_tb
FILELIST ?= kbd_display_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
SIM_ARGS ?= +verilator+error+limit+100
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
